//--- Makefile
# Verilator build for the multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= tb_md_unit
RTL_TOP    ?= md_unit
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/cpu_pkg.sv
package cpu_pkg;

	// operation codes follow the funct3 field of the RV32M instructions
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIV    = 3'b100,
		MD_DIVU   = 3'b101,
		MD_REM    = 3'b110,
		MD_REMU   = 3'b111
	} md_op_t;

	// multiplier view of the low two funct3 bits
	typedef enum logic [1:0] {
		UMULL  = 2'b00,
		SMULH  = 2'b01,
		SUMULH = 2'b10,
		UMULH  = 2'b11
	} mul_op_t;

	// divider view of the low two funct3 bits
	typedef enum logic [1:0] {
		DIV  = 2'b00,
		DIVU = 2'b01,
		REM  = 2'b10,
		REMU = 2'b11
	} div_op_t;

	// funct3 bit 2 set means the divider handles the operation
	localparam int MD_IS_DIV_BIT = 2;

	function automatic mul_op_t to_mul_op(input md_op_t op);
		return mul_op_t'(op[1:0]);
	endfunction

	function automatic div_op_t to_div_op(input md_op_t op);
		return div_op_t'(op[1:0]);
	endfunction

endpackage

//--- common/md_if.sv
`timescale 1ns/1ps

interface md_if #(
	parameter int xlen = 32
);
	import cpu_pkg::*;

	// request half
	logic            req_valid;
	logic            req_ready;
	md_op_t          req_op;
	logic [xlen-1:0] req_a;
	logic [xlen-1:0] req_b;

	// result half
	logic            rsp_valid;
	logic            rsp_ready;
	logic [xlen-1:0] rsp_data;

	modport dispatch (
		output req_valid, req_op, req_a, req_b, rsp_ready,
		input  req_ready, rsp_valid, rsp_data
	);

	modport unit (
		input  req_valid, req_op, req_a, req_b, rsp_ready,
		output req_ready, rsp_valid, rsp_data
	);

endinterface

//--- divider/int_divider.sv
`timescale 1ns/1ps

module int_divider #(
	parameter int xlen = 32
) (
	input logic clk,
	input logic reset,
	md_if.unit  bus
);
	import cpu_pkg::*;

	localparam int cnt_w = $clog2(xlen + 1);

	typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

	state_t state;
	logic [cnt_w-1:0] count;

	div_op_t op;
	logic    op_signed;
	logic    a_neg;
	logic    b_neg;
	logic    div_zero;
	logic    overflow;
	logic    accept;

	logic [xlen-1:0] abs_a;
	logic [xlen-1:0] abs_b;

	// quo_r starts as the dividend and fills with quotient bits from the right
	logic [xlen-1:0] quo_r;
	logic [xlen-1:0] rem_r;
	logic [xlen-1:0] dvs_r;
	logic            quo_neg;
	logic            rem_neg;
	logic            is_rem;

	logic [xlen:0]   shifted;
	logic [xlen:0]   diff;
	logic [xlen-1:0] quo_out;
	logic [xlen-1:0] rem_out;

	assign op        = to_div_op(bus.req_op);
	assign op_signed = (op == DIV) || (op == REM);
	assign a_neg     = op_signed && bus.req_a[xlen-1];
	assign b_neg     = op_signed && bus.req_b[xlen-1];
	assign abs_a     = a_neg ? -bus.req_a : bus.req_a;
	assign abs_b     = b_neg ? -bus.req_b : bus.req_b;

	assign div_zero = (bus.req_b == '0);
	assign overflow = op_signed && (bus.req_a == {1'b1, {(xlen-1){1'b0}}}) &&
		(bus.req_b == '1);

	assign bus.req_ready = (state == IDLE);
	assign bus.rsp_valid = (state == DONE);
	assign accept        = bus.req_valid && bus.req_ready;

	// one restoring step, the borrow bit tells whether the divisor fit
	assign shifted = {rem_r, quo_r[xlen-1]};
	assign diff    = shifted - {1'b0, dvs_r};

	assign quo_out      = quo_neg ? -quo_r : quo_r;
	assign rem_out      = rem_neg ? -rem_r : rem_r;
	assign bus.rsp_data = is_rem ? rem_out : quo_out;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						count <= '0;
						if (div_zero || overflow) begin
							state <= DONE;
						end else begin
							state <= RUN;
						end
					end
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == cnt_w'(xlen - 1)) begin
						state <= DONE;
					end
				end
				DONE: begin
					if (bus.rsp_ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			is_rem <= (op == REM) || (op == REMU);
			dvs_r  <= abs_b;
			if (div_zero) begin
				// RISC-V wants all ones and the untouched dividend here
				quo_r   <= '1;
				rem_r   <= bus.req_a;
				quo_neg <= 1'b0;
				rem_neg <= 1'b0;
			end else if (overflow) begin
				quo_r   <= bus.req_a;
				rem_r   <= '0;
				quo_neg <= 1'b0;
				rem_neg <= 1'b0;
			end else begin
				quo_r   <= abs_a;
				rem_r   <= '0;
				quo_neg <= a_neg ^ b_neg;
				rem_neg <= a_neg;
			end
		end else if (state == RUN) begin
			if (diff[xlen]) begin
				rem_r <= shifted[xlen-1:0];
			end else begin
				rem_r <= diff[xlen-1:0];
			end
			quo_r <= {quo_r[xlen-2:0], ~diff[xlen]};
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		count <= cnt_w'(xlen));

endmodule

//--- files.f
+incdir+sim
common/cpu_pkg.sv
common/md_if.sv
multiplier/int_multiplier.sv
divider/int_divider.sv
logic/md_dispatch.sv
logic/md_unit.sv
sim/tb_md_unit.sv

//--- logic/md_dispatch.sv
`timescale 1ns/1ps

module md_dispatch #(
	parameter int xlen = 32
) (
	input  logic             clk,
	input  logic             reset,

	input  logic             req_valid,
	output logic             req_ready,
	input  cpu_pkg::md_op_t  req_op,
	input  logic [xlen-1:0]  req_a,
	input  logic [xlen-1:0]  req_b,

	output logic             rsp_valid,
	input  logic             rsp_ready,
	output logic [xlen-1:0]  rsp_data,

	md_if.dispatch           mul_bus,
	md_if.dispatch           div_bus
);
	import cpu_pkg::*;

	logic busy;
	logic owner_div;
	logic sel_div;
	logic accept;
	logic done;

	assign sel_div = req_op[MD_IS_DIV_BIT];

	// operands and opcode go to both units and only valid is steered
	assign mul_bus.req_op = req_op;
	assign mul_bus.req_a  = req_a;
	assign mul_bus.req_b  = req_b;
	assign div_bus.req_op = req_op;
	assign div_bus.req_a  = req_a;
	assign div_bus.req_b  = req_b;

	assign mul_bus.req_valid = req_valid && !busy && !sel_div;
	assign div_bus.req_valid = req_valid && !busy && sel_div;

	assign req_ready = !busy && (sel_div ? div_bus.req_ready : mul_bus.req_ready);

	// the multiplier gates its req_ready with rsp_ready, so keep it high when idle
	assign mul_bus.rsp_ready = (busy && !owner_div) ? rsp_ready : 1'b1;
	assign div_bus.rsp_ready = busy && owner_div && rsp_ready;

	assign rsp_valid = busy && (owner_div ? div_bus.rsp_valid : mul_bus.rsp_valid);
	assign rsp_data  = owner_div ? div_bus.rsp_data : mul_bus.rsp_data;

	assign accept = req_valid && req_ready;
	assign done   = rsp_valid && rsp_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			owner_div <= 1'b0;
		end else if (accept) begin
			busy      <= 1'b1;
			owner_div <= sel_div;
		end else if (done) begin
			busy      <= 1'b0;
		end
	end

	// an outstanding operation keeps its unit from taking another request
	assert property (@(posedge clk) disable iff (reset)
		(busy && !rsp_valid) |-> !(owner_div ? div_bus.req_ready : mul_bus.req_ready));

	assert property (@(posedge clk) disable iff (reset)
		mul_bus.rsp_valid |-> (busy && !owner_div));

	assert property (@(posedge clk) disable iff (reset)
		div_bus.rsp_valid |-> (busy && owner_div));

endmodule

//--- logic/md_unit.sv
`timescale 1ns/1ps

module md_unit #(
	parameter int xlen       = 32,
	parameter int mul_cycles = 1
) (
	input  logic             clk,
	input  logic             reset,

	input  logic             req_valid,
	output logic             req_ready,
	input  cpu_pkg::md_op_t  req_op,
	input  logic [xlen-1:0]  req_a,
	input  logic [xlen-1:0]  req_b,

	output logic             rsp_valid,
	input  logic             rsp_ready,
	output logic [xlen-1:0]  rsp_data
);

	md_if #(.xlen(xlen)) mul_bus ();
	md_if #(.xlen(xlen)) div_bus ();

	md_dispatch #(
		.xlen      (xlen)
	) u_dispatch (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_op    (req_op),
		.req_a     (req_a),
		.req_b     (req_b),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data),
		.mul_bus   (mul_bus),
		.div_bus   (div_bus)
	);

	int_multiplier #(
		.xlen       (xlen),
		.mul_cycles (mul_cycles)
	) u_multiplier (
		.clk        (clk),
		.reset      (reset),
		.bus        (mul_bus)
	);

	int_divider #(
		.xlen  (xlen)
	) u_divider (
		.clk   (clk),
		.reset (reset),
		.bus   (div_bus)
	);

endmodule

//--- multiplier/int_multiplier.sv
`timescale 1ns/1ps

module int_multiplier #(
	parameter int xlen       = 32,
	parameter int mul_cycles = 1
) (
	input logic clk,
	input logic reset,
	md_if.unit  bus
);
	import cpu_pkg::*;

	localparam int cnt_w = $clog2(mul_cycles + 1);

	typedef enum logic {IDLE, CALC} state_t;

	state_t state;
	logic [cnt_w-1:0] count;

	mul_op_t op;
	mul_op_t op_buf;
	logic    sign_a;
	logic    sign_b;

	logic signed [xlen:0] a_ext;
	logic signed [xlen:0] b_ext;
	logic signed [xlen:0] a_buf;
	logic signed [xlen:0] b_buf;

	logic signed [2*xlen+1:0] full_prod;
	logic        [2*xlen-1:0] prod [mul_cycles+1];

	// prod_ok marks that the last stage holds the product of a_buf and b_buf
	logic prod_ok;
	logic rsp_valid_q;
	logic accept;
	logic reuse;

	assign op     = to_mul_op(bus.req_op);
	assign sign_a = (op == SMULH) || (op == SUMULH);
	assign sign_b = (op == SMULH);

	// one extra bit lets a single signed multiply cover all four variants
	assign a_ext = {bus.req_a[xlen-1] & sign_a, bus.req_a};
	assign b_ext = {bus.req_b[xlen-1] & sign_b, bus.req_b};

	assign bus.req_ready = bus.rsp_ready && (state == IDLE);
	assign bus.rsp_valid = rsp_valid_q;

	assign accept = bus.req_valid && bus.req_ready;
	assign reuse  = prod_ok && (a_ext == a_buf) && (b_ext == b_buf);

	assign full_prod = a_buf * b_buf;

	always_comb begin
		case (op_buf)
			UMULL:   bus.rsp_data = prod[mul_cycles][xlen-1:0];
			default: bus.rsp_data = prod[mul_cycles][2*xlen-1:xlen];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			count       <= '0;
			prod_ok     <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			count <= '0;
			if (reuse) begin
				// same extended operands, so the stored product is still good
				rsp_valid_q <= 1'b1;
				state       <= IDLE;
			end else begin
				rsp_valid_q <= 1'b0;
				prod_ok     <= 1'b0;
				state       <= CALC;
			end
		end else begin
			case (state)
				IDLE: begin
					if (rsp_valid_q && bus.rsp_ready) begin
						rsp_valid_q <= 1'b0;
					end
				end
				CALC: begin
					if (count == cnt_w'(mul_cycles)) begin
						rsp_valid_q <= 1'b1;
						prod_ok     <= 1'b1;
						state       <= IDLE;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_buf  <= a_ext;
			b_buf  <= b_ext;
			op_buf <= op;
		end
	end

	// the product ripples through mul_cycles+1 stages while calculating
	always_ff @(posedge clk) begin
		if (state == CALC) begin
			prod[0] <= full_prod[2*xlen-1:0];
			for (int i = 0; i < mul_cycles; i++) begin
				prod[i+1] <= prod[i];
			end
		end
	end

	// a result under back-pressure must not move
	assert property (@(posedge clk) disable iff (reset)
		(bus.rsp_valid && !bus.rsp_ready) |=> $stable(bus.rsp_data));

endmodule

//--- sim/md_checks.svh
`ifndef MD_CHECKS_SVH
`define MD_CHECKS_SVH

// multiply model from a signed product of the sign-extended operands
function automatic logic [xlen-1:0] mul_model(input md_op_t op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
	mul_op_t                  mop;
	logic signed [xlen:0]     ea;
	logic signed [xlen:0]     eb;
	logic signed [2*xlen+1:0] p;
	case (op)
		MD_MULH:   mop = SMULH;
		MD_MULHSU: mop = SUMULH;
		MD_MULHU:  mop = UMULH;
		default:   mop = UMULL;
	endcase
	ea = {((mop == SMULH) || (mop == SUMULH)) && a[xlen-1], a};
	eb = {(mop == SMULH) && b[xlen-1], b};
	p  = ea * eb;
	return (mop == UMULL) ? p[xlen-1:0] : p[2*xlen-1:xlen];
endfunction

function automatic logic [xlen-1:0] div_model(input md_op_t op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
	div_op_t                dop;
	logic signed [xlen-1:0] sa;
	logic signed [xlen-1:0] sb;
	logic        [xlen-1:0] q;
	logic        [xlen-1:0] r;
	logic                   is_signed;
	case (op)
		MD_DIV:  dop = DIV;
		MD_DIVU: dop = DIVU;
		MD_REM:  dop = REM;
		default: dop = REMU;
	endcase
	is_signed = (dop == DIV) || (dop == REM);
	sa = a;
	sb = b;
	if (b == '0) begin
		q = '1;
		r = a;
	end else if (is_signed && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1)) begin
		q = a;
		r = '0;
	end else if (is_signed) begin
		// signed division truncates toward zero, the remainder follows the dividend
		q = sa / sb;
		r = sa % sb;
	end else begin
		q = a / b;
		r = a % b;
	end
	return ((dop == DIV) || (dop == DIVU)) ? q : r;
endfunction

function automatic logic [xlen-1:0] expected_result(input md_op_t op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	return op[MD_IS_DIV_BIT] ? div_model(op, a, b) : mul_model(op, a, b);
endfunction

task automatic check_data(input string name, input md_op_t op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b, input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
	if (got !== exp) begin
		$display("Error: %s for %s a=%h b=%h got %h expected %h",
			name, op.name(), a, b, got, exp);
		errors++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Error: %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic check_latency(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("Error: latency of %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

`endif

//--- sim/tb_md_unit.sv
`timescale 1ns/1ps

module tb_md_unit;
	import cpu_pkg::*;

	localparam int xlen       = 32;
	localparam int mul_cycles = 1;
	localparam int max_wait   = 200;

	logic            clk;
	logic            reset;
	logic            req_valid;
	logic            req_ready;
	md_op_t          req_op;
	logic [xlen-1:0] req_a;
	logic [xlen-1:0] req_b;
	logic            rsp_valid;
	logic            rsp_ready;
	logic [xlen-1:0] rsp_data;

	int errors;
	int timeouts;
	int seed;

	`include "md_checks.svh"

	md_unit #(
		.xlen       (xlen),
		.mul_cycles (mul_cycles)
	) u_dut (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_op    (req_op),
		.req_a     (req_a),
		.req_b     (req_b),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [xlen-1:0] corner(input int i);
		case (i)
			0:       return '0;
			1:       return xlen'(1);
			2:       return '1;
			3:       return {1'b1, {(xlen-1){1'b0}}};
			default: return {1'b0, {(xlen-1){1'b1}}};
		endcase
	endfunction

	// ends on the falling edge after the accepting edge with valid dropped
	task automatic send_req(input md_op_t op, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		int n;
		@(negedge clk);
		req_valid = 1'b1;
		req_op    = op;
		req_a     = a;
		req_b     = b;
		n = 0;
		#1;
		while (!req_ready && n < max_wait) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!req_ready) begin
			$display("request %s was never accepted", op.name());
			timeouts++;
		end else begin
			@(posedge clk);
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_rsp(output int lat);
		lat = 1;
		while (!rsp_valid && lat < max_wait) begin
			@(negedge clk);
			lat++;
		end
		if (!rsp_valid) begin
			$display("no result arrived within %0d cycles", max_wait);
			timeouts++;
		end
	endtask

	task automatic run_op(input md_op_t op, input logic [xlen-1:0] a, input logic [xlen-1:0] b,
			output int lat);
		send_req(op, a, b);
		wait_rsp(lat);
		check_data("rsp_data", op, a, b, rsp_data, expected_result(op, a, b));
		@(posedge clk);
	endtask

	task automatic after_reset();
		check_flag("req_ready", req_ready, 1'b1);
		check_flag("rsp_valid", rsp_valid, 1'b0);
		check_flag("mul_bus.rsp_valid", u_dut.mul_bus.rsp_valid, 1'b0);
		check_flag("div_bus.rsp_valid", u_dut.div_bus.rsp_valid, 1'b0);
	endtask

	// a repeated operand pair only reuses the product if the extension matches too
	task automatic mul_reuse();
		int lat;
		run_op(MD_MULH, 32'h0001_2345, 32'h0000_6789, lat);
		check_latency("MULH", lat, mul_cycles + 2);
		run_op(MD_MUL, 32'h0001_2345, 32'h0000_6789, lat);
		check_latency("MUL after MULH", lat, 1);
		run_op(MD_MULHU, 32'h0001_2345, 32'h0000_6789, lat);
		check_latency("MULHU after MUL", lat, 1);
		run_op(MD_MULH, 32'hfff0_1234, 32'h0000_0abc, lat);
		check_latency("MULH negative", lat, mul_cycles + 2);
		run_op(MD_MULHU, 32'hfff0_1234, 32'h0000_0abc, lat);
		check_latency("MULHU after MULH", lat, mul_cycles + 2);
		run_op(MD_MUL, 32'hfff0_1234, 32'h0000_0abc, lat);
		check_latency("MUL after MULHU", lat, 1);
		run_op(MD_MULHSU, 32'hfff0_1234, 32'h0000_0abc, lat);
		check_latency("MULHSU after MUL", lat, mul_cycles + 2);
	endtask

	task automatic mul_corners();
		int lat;
		for (int k = 0; k < 4; k++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					run_op(md_op_t'(3'(k)), corner(i), corner(j), lat);
	endtask

	task automatic mul_random();
		int              lat;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		for (int i = 0; i < 50; i++) begin
			a = $random(seed);
			b = $random(seed);
			for (int k = 0; k < 4; k++)
				run_op(md_op_t'(3'(k)), a, b, lat);
		end
	endtask

	task automatic div_corners();
		int              lat;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic            quick;
		for (int k = 4; k < 8; k++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					a = corner(i);
					b = corner(j);
					quick = (b == '0) || (!k[0] && (i == 3) && (j == 2));
					run_op(md_op_t'(3'(k)), a, b, lat);
					check_latency("divide", lat, quick ? 1 : xlen + 1);
				end
			end
		end
	endtask

	task automatic div_random();
		int              lat;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		for (int i = 0; i < 40; i++) begin
			a = $random(seed);
			b = $random(seed);
			// small divisors give long quotients
			if (i % 2 == 1)
				b = b & 32'h0000_ffff;
			for (int k = 4; k < 8; k++)
				run_op(md_op_t'(3'(k)), a, b, lat);
		end
	endtask

	task automatic backpressure(input md_op_t op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		int              lat;
		int              hold;
		logic [xlen-1:0] exp;
		exp = expected_result(op, a, b);
		@(negedge clk);
		rsp_ready = 1'b0;
		send_req(op, a, b);
		wait_rsp(lat);
		hold = 1 + ($unsigned($random(seed)) % 12);
		repeat (hold) begin
			@(negedge clk);
			check_flag("rsp_valid", rsp_valid, 1'b1);
			check_flag("req_ready", req_ready, 1'b0);
			check_data("rsp_data", op, a, b, rsp_data, exp);
		end
		rsp_ready = 1'b1;
		check_data("rsp_data", op, a, b, rsp_data, exp);
		@(posedge clk);
		@(negedge clk);
		check_flag("rsp_valid", rsp_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
	endtask

	task automatic alternating();
		int         lat;
		logic [1:0] low;
		logic       sel;
		for (int i = 0; i < 20; i++) begin
			low = 2'($random(seed));
			sel = (i % 2 == 1);
			run_op(md_op_t'({sel, low}), $random(seed), $random(seed), lat);
		end
	endtask

	initial begin
		errors    = 0;
		timeouts  = 0;
		seed      = 32'hee1d;
		reset     = 1'b1;
		req_valid = 1'b0;
		req_op    = MD_MUL;
		req_a     = '0;
		req_b     = '0;
		rsp_ready = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		after_reset();
		mul_reuse();
		mul_corners();
		mul_random();
		div_corners();
		div_random();
		backpressure(MD_MULHU, 32'hdead_beef, 32'h1234_5678);
		backpressure(MD_REM, 32'h8765_4321, 32'h0000_0123);
		alternating();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
